// File: files.f
+incdir+include
source/hdmi_tx_pkg.sv
source/mode_decoder.sv
source/adv_reg_sequencer.sv
source/i2c_write_master.sv
source/hdmi_tx_config_top.sv
test/i2c_target_model.sv
test/hdmi_tx_config_tb.sv

// File: Bender.yml
package:
  name: hdmi_tx_config

export_include_dirs:
  - include

sources:
  - source/hdmi_tx_pkg.sv
  - source/mode_decoder.sv
  - source/adv_reg_sequencer.sv
  - source/i2c_write_master.sv
  - source/hdmi_tx_config_top.sv
  - target: test
    files:
      - test/i2c_target_model.sv
      - test/hdmi_tx_config_tb.sv

// File: test/hdmi_tx_config_tb.sv
`include "hdmi_tx_params.svh"

module hdmi_tx_config_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 20;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 7 * 40 * 2 * `I2C_HALF_PERIOD + 200;

    typedef struct packed {
        hdmi_tx_pkg::code_byte_t  mode_code;
        hdmi_tx_pkg::code_byte_t  phase_code;
        hdmi_tx_pkg::adv_config_t cfg;
        hdmi_tx_pkg::reg_data_t   delay;
        logic                     refuse;
        logic                     settle;  // 0 means changed again mid-sequence
    } row_t;

    logic                     clock;
    logic                     rst_n;
    hdmi_tx_pkg::code_byte_t  mode_code;
    hdmi_tx_pkg::code_byte_t  phase_code;
    logic                     sda_in;
    hdmi_tx_pkg::adv_config_t adv_config;
    hdmi_tx_pkg::reg_data_t   clock_delay;
    logic                     reconf;
    logic                     config_busy;
    logic                     ack_fail;
    logic                     scl_oe;
    logic                     sda_oe;
    logic                     refuse;
    logic                     write_seen;
    hdmi_tx_pkg::reg_write_t  write_rec;
    hdmi_tx_pkg::reg_write_t  seen_q [$];
    row_t                     rows [NUM_ROWS];

    hdmi_tx_config_top hdmi_tx_config_top_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .mode_code   (mode_code),
        .phase_code  (phase_code),
        .sda_in      (sda_in),
        .adv_config  (adv_config),
        .clock_delay (clock_delay),
        .reconf      (reconf),
        .config_busy (config_busy),
        .ack_fail    (ack_fail),
        .scl_oe      (scl_oe),
        .sda_oe      (sda_oe)
    );

    i2c_target_model i2c_target_model_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe),
        .refuse     (refuse),
        .sda_in     (sda_in),
        .write_seen (write_seen),
        .write_rec  (write_rec)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        if (write_seen) begin
            seen_q.push_back(write_rec);
        end
    end

    function automatic row_t make_row(hdmi_tx_pkg::code_byte_t m, hdmi_tx_pkg::code_byte_t p,
                                      hdmi_tx_pkg::video_mode_t vm, hdmi_tx_pkg::vic_t vic,
                                      logic [1:0] pr, logic il, hdmi_tx_pkg::reg_data_t d,
                                      logic refuse_row, logic settle_row);
        return '{mode_code: m, phase_code: p,
                 cfg: '{mode: vm, vic: vic, pixel_repeat: pr, interlaced: il},
                 delay: d, refuse: refuse_row, settle: settle_row};
    endfunction

    // register write list of the transmitter bring-up
    function automatic hdmi_tx_pkg::reg_write_t expected_write(row_t r, int idx);
        case (idx)
            0: return '{addr: 8'h41, data: 8'h10};
            1: return '{addr: 8'h98, data: 8'h03};
            2: return '{addr: 8'h3c, data: r.cfg.vic};
            3: return '{addr: 8'h3b, data: {6'd0, r.cfg.pixel_repeat}};
            4: return '{addr: 8'hba, data: r.delay};
            default: return '{addr: 8'haf, data: r.cfg.interlaced ? 8'h16 : 8'h06};
        endcase
    endfunction

    task automatic load_table();
        rows[0]  = make_row('h01, 3, hdmi_tx_pkg::mode_960p, 0, 0, 0, 'h60, 0, 1);
        rows[1]  = make_row('h02, 3, hdmi_tx_pkg::mode_480p, 2, 0, 0, 'h60, 0, 1);
        rows[2]  = make_row('h82, 3, hdmi_tx_pkg::mode_480p, 2, 0, 0, 'h60, 0, 1);  // bit 7
        rows[3]  = make_row('h03, 0, hdmi_tx_pkg::mode_vga, 1, 0, 0, 'h00, 0, 1);
        rows[4]  = make_row('h08, 1, hdmi_tx_pkg::mode_576p, 17, 0, 0, 'h20, 0, 1);
        rows[5]  = make_row('h0b, 1, hdmi_tx_pkg::mode_576p, 17, 0, 0, 'h20, 0, 1);
        rows[6]  = make_row('h10, 2, hdmi_tx_pkg::mode_240p_1080p, 16, 0, 0, 'h40, 0, 1);
        rows[7]  = make_row('h11, 4, hdmi_tx_pkg::mode_240p_960p, 0, 0, 0, 'h80, 0, 1);
        rows[8]  = make_row('h12, 5, hdmi_tx_pkg::mode_240p_480p, 2, 0, 0, 'ha0, 0, 1);
        rows[9]  = make_row('h13, 6, hdmi_tx_pkg::mode_240p_vga, 1, 0, 0, 'hc0, 0, 1);
        rows[10] = make_row('h20, 7, hdmi_tx_pkg::mode_480i, 6, 1, 1, 'he0, 0, 1);
        rows[11] = make_row('h22, 9, hdmi_tx_pkg::mode_480i, 6, 1, 1, 'he0, 0, 1);
        rows[12] = make_row('h05, 9, hdmi_tx_pkg::mode_480i, 6, 1, 1, 'he0, 0, 1);  // unlisted
        rows[13] = make_row('h41, 3, hdmi_tx_pkg::mode_576i, 21, 1, 1, 'h60, 0, 1);
        rows[14] = make_row('h43, 3, hdmi_tx_pkg::mode_576i, 21, 1, 1, 'h60, 0, 1);
        rows[15] = make_row('h09, 3, hdmi_tx_pkg::mode_576p, 17, 0, 0, 'h60, 0, 0);
        rows[16] = make_row('h00, 2, hdmi_tx_pkg::mode_1080p, 16, 0, 0, 'h40, 0, 1);
        rows[17] = make_row('h21, 2, hdmi_tx_pkg::mode_480i, 6, 1, 1, 'h40, 1, 1);
        rows[18] = make_row('h0a, 2, hdmi_tx_pkg::mode_576p, 17, 0, 0, 'h40, 1, 1);
        rows[19] = make_row('h40, 5, hdmi_tx_pkg::mode_576i, 21, 1, 1, 'ha0, 0, 1);
    endtask

    task automatic stop_failed();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_config(string what, hdmi_tx_pkg::adv_config_t got,
                                hdmi_tx_pkg::adv_config_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_delay(string what, hdmi_tx_pkg::reg_data_t got,
                               hdmi_tx_pkg::reg_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_write(string what, hdmi_tx_pkg::reg_write_t got,
                               hdmi_tx_pkg::reg_write_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_failed();
        end
    endtask

    // exact is 0 after a restart, then only the tail has to match
    task automatic check_writes(row_t r, logic exact);
        int expected_n;
        int base;
        expected_n = r.refuse ? 0 : `ADV_WRITE_COUNT;
        if (exact ? (seen_q.size() != expected_n) : (seen_q.size() < expected_n)) begin
            $display("[ERROR] %0t ns: target logged %0d writes, expected %0d",
                     $time, seen_q.size(), expected_n);
            stop_failed();
        end
        base = seen_q.size() - expected_n;
        for (int k = 0; k < expected_n; k++) begin
            check_write($sformatf("write %0d", k), seen_q[base + k], expected_write(r, k));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, table not finished", WATCHDOG_CYCLES);
        stop_failed();
    end

    initial begin
        int unsigned hold;
        logic        exact;
        void'($urandom(91));
        load_table();
        rst_n      = 1'b0;
        mode_code  = 8'h00;
        phase_code = `RESET_PHASE_CODE;
        refuse     = 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_config("reset adv_config", adv_config, '{hdmi_tx_pkg::mode_1080p, 16, 0, 0});
        check_delay("reset clock_delay", clock_delay, 8'h60);
        check_flag("reset reconf", reconf, 1'b0);
        check_flag("reset config_busy", config_busy, 1'b0);
        check_flag("reset ack_fail", ack_fail, 1'b0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            exact = (i == 0) || rows[i - 1].settle;
            if (exact) begin
                seen_q.delete();
            end
            @(posedge clock);
            mode_code  <= rows[i].mode_code;
            phase_code <= rows[i].phase_code;
            refuse     <= rows[i].refuse;
            @(posedge clock);
            @(negedge clock);
            check_config("adv_config", adv_config, rows[i].cfg);
            check_delay("clock_delay", clock_delay, rows[i].delay);
            check_flag("reconf", reconf, 1'b1);
            @(negedge clock);
            check_flag("reconf one cycle later", reconf, 1'b0);
            check_flag("config_busy", config_busy, 1'b1);
            if (rows[i].settle) begin
                while (config_busy) @(negedge clock);
                repeat (4) @(negedge clock);  // last stop reaches the queue
                check_flag("ack_fail", ack_fail, rows[i].refuse);
                check_writes(rows[i], exact);
                hold = 1 + $urandom % 8;
            end else begin
                hold = 20 + $urandom % 600;  // still mid-sequence
            end
            repeat (hold) @(negedge clock);
            if (rows[i].settle) begin
                check_flag("ack_fail while idle", ack_fail, rows[i].refuse);
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: test/i2c_target_model.sv
`include "hdmi_tx_params.svh"

module i2c_target_model (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    scl_oe,
    input  logic                    sda_oe,
    input  logic                    refuse,
    output logic                    sda_in,
    output logic                    write_seen,
    output hdmi_tx_pkg::reg_write_t write_rec
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                   scl;
    logic                   sda;
    logic                   scl_q;
    logic                   sda_q;
    logic                   ack_drive;
    logic [3:0]             bit_cnt;  // 8 during ack low half, 9 after ack clock
    logic [1:0]             byte_cnt;
    logic [7:0]             shreg;
    hdmi_tx_pkg::reg_data_t bytes [3];

    // open-drain lines with pull-ups
    assign scl    = !scl_oe;
    assign sda    = !(sda_oe || ack_drive);
    assign sda_in = sda;

    always @(posedge clock) begin
        write_seen <= 1'b0;
        if (!rst_n) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            ack_drive <= 1'b0;
            bit_cnt   <= 4'd0;
            byte_cnt  <= 2'd0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda) begin  // start
                bit_cnt  <= 4'd0;
                byte_cnt <= 2'd0;
            end else if (scl_q && scl && !sda_q && sda) begin  // stop
                if (byte_cnt == 2'd3) begin
                    write_seen <= 1'b1;
                    write_rec  <= '{addr: bytes[1], data: bytes[2]};
                end
                byte_cnt <= 2'd0;
            end else if (!scl_q && scl) begin
                if (bit_cnt == 4'd8) begin
                    bit_cnt <= 4'd9;
                end else begin
                    shreg   <= {shreg[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7 && byte_cnt != 2'd3) begin
                        bytes[byte_cnt] <= {shreg[6:0], sda};
                        byte_cnt        <= byte_cnt + 2'd1;
                    end
                end
            end else if (scl_q && !scl) begin
                if (bit_cnt == 4'd8) begin
                    // only answer our own address
                    ack_drive <= !refuse && (byte_cnt != 2'd1 || bytes[0] == `ADV_I2C_ADDR);
                end else if (bit_cnt == 4'd9) begin
                    ack_drive <= 1'b0;
                    bit_cnt   <= 4'd0;
                end
            end
        end
    end

endmodule

// File: source/hdmi_tx_config_top.sv
module hdmi_tx_config_top (
    input  logic                     clock,
    input  logic                     rst_n,
    input  hdmi_tx_pkg::code_byte_t  mode_code,
    input  hdmi_tx_pkg::code_byte_t  phase_code,
    input  logic                     sda_in,
    output hdmi_tx_pkg::adv_config_t adv_config,
    output hdmi_tx_pkg::reg_data_t   clock_delay,
    output logic                     reconf,
    output logic                     config_busy,
    output logic                     ack_fail,
    output logic                     scl_oe,
    output logic                     sda_oe
);

    logic                    write_start;
    hdmi_tx_pkg::reg_write_t write_req;
    logic                    write_done;
    logic                    nack;

    mode_decoder mode_decoder_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .mode_code   (mode_code),
        .phase_code  (phase_code),
        .adv_config  (adv_config),
        .clock_delay (clock_delay),
        .reconf      (reconf)
    );

    adv_reg_sequencer adv_reg_sequencer_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .adv_config  (adv_config),
        .clock_delay (clock_delay),
        .reconf      (reconf),
        .write_done  (write_done),
        .nack        (nack),
        .write_start (write_start),
        .write_req   (write_req),
        .config_busy (config_busy),
        .ack_fail    (ack_fail)
    );

    i2c_write_master i2c_write_master_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .write_start (write_start),
        .write_req   (write_req),
        .sda_in      (sda_in),
        .write_done  (write_done),
        .nack        (nack),
        .scl_oe      (scl_oe),
        .sda_oe      (sda_oe)
    );

endmodule

// File: source/i2c_write_master.sv
`include "hdmi_tx_params.svh"

module i2c_write_master (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    write_start,
    input  hdmi_tx_pkg::reg_write_t write_req,
    input  logic                    sda_in,
    output logic                    write_done,
    output logic                    nack,
    output logic                    scl_oe,
    output logic                    sda_oe
);

    localparam int DIV_W = $clog2(`I2C_HALF_PERIOD + 1);

    hdmi_tx_pkg::i2c_state_t state;
    hdmi_tx_pkg::reg_write_t req;
    hdmi_tx_pkg::reg_data_t  shreg;
    hdmi_tx_pkg::reg_data_t  next_byte;
    logic [DIV_W-1:0]        div;
    logic                    tick;
    logic                    phase;  // 0 scl low half, 1 scl high half
    logic [2:0]              bit_cnt;
    logic [1:0]              byte_idx;
    logic                    nack_r;
    logic                    load_first;
    logic                    load_next;
    logic                    shift_bit;

    assign tick       = (div == DIV_W'(`I2C_HALF_PERIOD - 1));
    assign next_byte  = (byte_idx == 2'd0) ? req.addr : req.data;
    assign load_first = (state == hdmi_tx_pkg::i2c_idle) && write_start;
    assign shift_bit  = (state == hdmi_tx_pkg::i2c_shift) && phase && tick
                        && (bit_cnt != 3'd0);
    assign load_next  = (state == hdmi_tx_pkg::i2c_ack) && phase && tick;

    always_ff @(posedge clock) begin
        if (load_first) begin
            req   <= write_req;
            shreg <= `ADV_I2C_ADDR;
        end else if (shift_bit) begin
            shreg <= {shreg[6:0], 1'b0};
        end else if (load_next) begin
            shreg <= next_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= hdmi_tx_pkg::i2c_idle;
            div        <= '0;
            phase      <= 1'b0;
            bit_cnt    <= 3'd0;
            byte_idx   <= 2'd0;
            nack_r     <= 1'b0;
            write_done <= 1'b0;
            nack       <= 1'b0;
            scl_oe     <= 1'b0;
            sda_oe     <= 1'b0;
        end else begin
            write_done <= 1'b0;
            nack       <= 1'b0;
            if (state == hdmi_tx_pkg::i2c_idle || tick) begin
                div <= '0;
            end else begin
                div <= div + 1'b1;
            end
            case (state)
                hdmi_tx_pkg::i2c_idle: begin
                    if (write_start) begin
                        state    <= hdmi_tx_pkg::i2c_start;
                        phase    <= 1'b0;
                        byte_idx <= 2'd0;
                        nack_r   <= 1'b0;
                    end
                end

                // half period bus free, then sda falls with scl high
                hdmi_tx_pkg::i2c_start: begin
                    if (tick && !phase) begin
                        sda_oe <= 1'b1;
                        phase  <= 1'b1;
                    end else if (tick) begin
                        scl_oe  <= 1'b1;
                        sda_oe  <= ~shreg[7];
                        bit_cnt <= 3'd7;
                        phase   <= 1'b0;
                        state   <= hdmi_tx_pkg::i2c_shift;
                    end
                end

                hdmi_tx_pkg::i2c_shift: begin
                    if (tick && !phase) begin
                        scl_oe <= 1'b0;
                        phase  <= 1'b1;
                    end else if (tick) begin
                        scl_oe <= 1'b1;
                        phase  <= 1'b0;
                        if (bit_cnt == 3'd0) begin
                            sda_oe <= 1'b0;  // release for ack
                            state  <= hdmi_tx_pkg::i2c_ack;
                        end else begin
                            sda_oe  <= ~shreg[6];
                            bit_cnt <= bit_cnt - 3'd1;
                        end
                    end
                end

                hdmi_tx_pkg::i2c_ack: begin
                    if (tick && !phase) begin
                        scl_oe <= 1'b0;
                        phase  <= 1'b1;
                    end else if (tick) begin
                        scl_oe <= 1'b1;
                        phase  <= 1'b0;
                        nack_r <= nack_r | sda_in;
                        if ((sda_in && byte_idx == 2'd0) || byte_idx == 2'd2) begin
                            sda_oe <= 1'b1;  // hold low for stop
                            state  <= hdmi_tx_pkg::i2c_stop;
                        end else begin
                            sda_oe   <= ~next_byte[7];
                            bit_cnt  <= 3'd7;
                            byte_idx <= byte_idx + 2'd1;
                            state    <= hdmi_tx_pkg::i2c_shift;
                        end
                    end
                end

                hdmi_tx_pkg::i2c_stop: begin
                    if (tick && !phase) begin
                        scl_oe <= 1'b0;
                        phase  <= 1'b1;
                    end else if (tick) begin
                        sda_oe     <= 1'b0;  // sda rises with scl high
                        phase      <= 1'b0;
                        write_done <= 1'b1;
                        nack       <= nack_r;
                        state      <= hdmi_tx_pkg::i2c_idle;
                    end
                end

                default: state <= hdmi_tx_pkg::i2c_idle;
            endcase
        end
    end

endmodule

// File: source/adv_reg_sequencer.sv
`include "hdmi_tx_params.svh"

module adv_reg_sequencer (
    input  logic                     clock,
    input  logic                     rst_n,
    input  hdmi_tx_pkg::adv_config_t adv_config,
    input  hdmi_tx_pkg::reg_data_t   clock_delay,
    input  logic                     reconf,
    input  logic                     write_done,
    input  logic                     nack,
    output logic                     write_start,
    output hdmi_tx_pkg::reg_write_t  write_req,
    output logic                     config_busy,
    output logic                     ack_fail
);

    localparam logic [2:0] LAST_IDX = 3'(`ADV_WRITE_COUNT - 1);

    hdmi_tx_pkg::seq_state_t state;
    logic [2:0]              idx;
    logic                    restart_pend;

    assign write_start = (state == hdmi_tx_pkg::seq_issue);
    assign config_busy = (state != hdmi_tx_pkg::seq_idle);

    // values follow the live config, the master copies them on write_start
    always_comb begin
        case (idx)
            3'd0: write_req = '{addr: 8'h41, data: 8'h10};  // power up
            3'd1: write_req = '{addr: 8'h98, data: 8'h03};  // fixed per datasheet
            3'd2: write_req = '{addr: 8'h3c, data: adv_config.vic};
            3'd3: write_req = '{addr: 8'h3b, data: {6'd0, adv_config.pixel_repeat}};
            3'd4: write_req = '{addr: 8'hba, data: clock_delay};
            default: begin
                write_req.addr = 8'haf;
                write_req.data = adv_config.interlaced ? 8'h16 : 8'h06;  // hdmi mode
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= hdmi_tx_pkg::seq_idle;
            idx          <= 3'd0;
            restart_pend <= 1'b0;
            ack_fail     <= 1'b0;
        end else begin
            case (state)
                hdmi_tx_pkg::seq_idle: begin
                    if (reconf) begin
                        state    <= hdmi_tx_pkg::seq_issue;
                        idx      <= 3'd0;
                        ack_fail <= 1'b0;  // new sequence
                    end
                end

                hdmi_tx_pkg::seq_issue: begin
                    state <= hdmi_tx_pkg::seq_wait_done;
                    if (reconf) begin
                        restart_pend <= 1'b1;
                    end
                end

                hdmi_tx_pkg::seq_wait_done: begin
                    if (write_done) begin
                        restart_pend <= 1'b0;
                        if (restart_pend || reconf) begin
                            // config moved under us, start over
                            state    <= hdmi_tx_pkg::seq_issue;
                            idx      <= 3'd0;
                            ack_fail <= 1'b0;
                        end else begin
                            if (nack) begin
                                ack_fail <= 1'b1;
                            end
                            if (idx == LAST_IDX) begin
                                state <= hdmi_tx_pkg::seq_idle;
                            end else begin
                                state <= hdmi_tx_pkg::seq_issue;
                                idx   <= idx + 3'd1;
                            end
                        end
                    end else if (reconf) begin
                        restart_pend <= 1'b1;  // let the current write finish
                    end
                end

                default: state <= hdmi_tx_pkg::seq_idle;
            endcase
        end
    end

endmodule

// File: source/mode_decoder.sv
`include "hdmi_tx_params.svh"

module mode_decoder (
    input  logic                     clock,
    input  logic                     rst_n,
    input  hdmi_tx_pkg::code_byte_t  mode_code,
    input  hdmi_tx_pkg::code_byte_t  phase_code,
    output hdmi_tx_pkg::adv_config_t adv_config,
    output hdmi_tx_pkg::reg_data_t   clock_delay,
    output logic                     reconf
);

    hdmi_tx_pkg::code_byte_t  mode_prev;
    hdmi_tx_pkg::code_byte_t  phase_prev;
    hdmi_tx_pkg::adv_config_t lut_cfg;
    logic                     mode_changed;
    logic                     phase_changed;

    function automatic hdmi_tx_pkg::adv_config_t make_cfg(
        input hdmi_tx_pkg::video_mode_t m,
        input hdmi_tx_pkg::vic_t        v,
        input logic [1:0]               pr,
        input logic                     il
    );
        return '{mode: m, vic: v, pixel_repeat: pr, interlaced: il};
    endfunction

    assign mode_changed  = (mode_code != mode_prev);
    assign phase_changed = (phase_code != phase_prev);

    // bit 7 plays no part in the lookup
    always_comb begin
        case (mode_code[6:0])
            7'h00: lut_cfg = make_cfg(hdmi_tx_pkg::mode_1080p, 8'd16, 2'd0, 1'b0);
            7'h01: lut_cfg = make_cfg(hdmi_tx_pkg::mode_960p, 8'd0, 2'd0, 1'b0);
            7'h02: lut_cfg = make_cfg(hdmi_tx_pkg::mode_480p, 8'd2, 2'd0, 1'b0);
            7'h03: lut_cfg = make_cfg(hdmi_tx_pkg::mode_vga, 8'd1, 2'd0, 1'b0);
            7'h08, 7'h09, 7'h0a, 7'h0b:
                lut_cfg = make_cfg(hdmi_tx_pkg::mode_576p, 8'd17, 2'd0, 1'b0);
            7'h10: lut_cfg = make_cfg(hdmi_tx_pkg::mode_240p_1080p, 8'd16, 2'd0, 1'b0);
            7'h11: lut_cfg = make_cfg(hdmi_tx_pkg::mode_240p_960p, 8'd0, 2'd0, 1'b0);
            7'h12: lut_cfg = make_cfg(hdmi_tx_pkg::mode_240p_480p, 8'd2, 2'd0, 1'b0);
            7'h13: lut_cfg = make_cfg(hdmi_tx_pkg::mode_240p_vga, 8'd1, 2'd0, 1'b0);
            7'h20, 7'h21, 7'h22, 7'h23:
                lut_cfg = make_cfg(hdmi_tx_pkg::mode_480i, 8'd6, 2'd1, 1'b1);  // 2x repeat
            7'h40, 7'h41, 7'h42, 7'h43:
                lut_cfg = make_cfg(hdmi_tx_pkg::mode_576i, 8'd21, 2'd1, 1'b1);
            default: lut_cfg = adv_config;  // unlisted code keeps config
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mode_prev   <= `RESET_MODE_CODE;
            phase_prev  <= `RESET_PHASE_CODE;
            adv_config  <= make_cfg(hdmi_tx_pkg::mode_1080p, `RESET_VIC, 2'd0, 1'b0);
            clock_delay <= `RESET_CLOCK_DELAY;
            reconf      <= 1'b0;
        end else begin
            mode_prev  <= mode_code;
            phase_prev <= phase_code;
            reconf     <= mode_changed || phase_changed;
            if (mode_changed) begin
                adv_config <= lut_cfg;
            end
            if (phase_changed && (phase_code < 8'd8)) begin
                clock_delay <= {phase_code[2:0], 5'd0};  // 0.4 ns steps with code 3 at zero
            end
        end
    end

endmodule

// File: source/hdmi_tx_pkg.sv
package hdmi_tx_pkg;

    typedef logic [7:0] code_byte_t;  // host mode or phase byte
    typedef logic [7:0] vic_t;        // CEA vic, 0 for non-CEA
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    typedef enum logic [3:0] {
        mode_1080p,
        mode_960p,
        mode_480p,
        mode_vga,
        mode_576p,
        mode_240p_1080p,
        mode_240p_960p,
        mode_240p_480p,
        mode_240p_vga,
        mode_480i,
        mode_576i
    } video_mode_t;

    typedef struct packed {
        video_mode_t mode;
        vic_t        vic;
        logic [1:0]  pixel_repeat;
        logic        interlaced;
    } adv_config_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

    // literals carry a prefix, both enums share the package scope
    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_wait_done
    } seq_state_t;

    typedef enum logic [2:0] {
        i2c_idle,
        i2c_start,
        i2c_shift,
        i2c_ack,
        i2c_stop
    } i2c_state_t;

endpackage

// File: include/hdmi_tx_params.svh
`ifndef HDMI_TX_PARAMS_SVH
`define HDMI_TX_PARAMS_SVH

// ADV7513 8-bit write address, PD pin low
`define ADV_I2C_ADDR 8'h72

// clock cycles per half SCL period, kept small for simulation
`define I2C_HALF_PERIOD 4

// entries in the register write list
`define ADV_WRITE_COUNT 6

// host byte values assumed before the first change
`define RESET_MODE_CODE 8'h00
`define RESET_PHASE_CODE 8'd3

// 1080p defaults
`define RESET_VIC 8'd16

// clock delay code 3, no delay
`define RESET_CLOCK_DELAY 8'h60

`endif
